// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --assert --timing
TOP ?= burst_packer_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/burst_ctrl.sv
/*
 * burst controller FSM
 * chooses full bursts or flushes from the FIFO occupancy
 * and issues tagged read strobes
 */

`timescale 1ns/1ps

module burst_ctrl #(
	parameter int AW = 3,
	parameter int BURST_LEN = 4
) (
	input logic clk,
	input logic rst,
	// level, blocks new frames while high
	input logic hold,
	// FIFO status, count is -1 when empty
	input logic signed [AW:0] count,
	input logic empty,
	// idle timeout from the flush timer
	input logic expire,
	// read strobe with frame marks
	output burst_pkg::rd_tag_t rd,
	// lets the flush timer count
	output logic run
);

	burst_pkg::ctrl_state_e state;

	// number of words waiting, 0 up to the depth
	logic [AW:0] occ;
	// reads left in the current frame
	logic [AW:0] remain;
	// next read is the first of its frame
	logic first_pend;
	logic start_burst;
	logic start_flush;

	// signed count is one below the occupancy
	assign occ = empty ? '0 : $unsigned(count) + 1'b1;

	// frames start only from IDLE and only with hold low
	assign start_burst = (state == burst_pkg::IDLE) && !hold
		&& (occ >= (AW+1)'(BURST_LEN));
	assign start_flush = (state == burst_pkg::IDLE) && !hold
		&& !start_burst && expire && !empty;

	// timer runs only while a short remainder sits idle
	assign run = (state == burst_pkg::IDLE) && !empty && !hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= burst_pkg::IDLE;
			remain <= '0;
			first_pend <= 1'b0;
		end else begin
			case (state)
				burst_pkg::IDLE: begin
					if (start_burst) begin
						state <= burst_pkg::BURST;
						remain <= (AW+1)'(BURST_LEN);
						first_pend <= 1'b1;
					end else if (start_flush) begin
						// later writes wait for the next frame
						state <= burst_pkg::FLUSH;
						remain <= occ;
						first_pend <= 1'b1;
					end
				end
				burst_pkg::BURST, burst_pkg::FLUSH: begin
					// one read per cycle until the frame is done
					first_pend <= 1'b0;
					remain <= remain - 1'b1;
					if (remain == (AW+1)'(1)) begin
						// always back through IDLE for at least a cycle
						state <= burst_pkg::IDLE;
					end
				end
				default: begin
					state <= burst_pkg::IDLE;
				end
			endcase
		end
	end

	// reads run on every cycle spent in a frame state
	always_comb begin
		rd = '0;
		if (state != burst_pkg::IDLE) begin
			rd.re = 1'b1;
			rd.first = first_pend;
			rd.last = remain == (AW+1)'(1);
		end
	end

endmodule

// File: design/burst_packer.sv
/*
 * burst packer top level
 * short FIFO, flush timer, burst controller and output tagger
 */

`timescale 1ns/1ps

module burst_packer #(
	// depth is 2**AW
	parameter int AW = 3,
	// words per full frame, 2 up to the depth
	parameter int BURST_LEN = 4,
	// idle cycles before a short frame is flushed
	parameter int FLUSH_CYCLES = 16
) (
	input logic clk,
	input logic rst,
	input logic [burst_pkg::WORD_W-1:0] din,
	input logic we,
	// level, keeps new frames from starting
	input logic hold,
	output burst_pkg::frame_word_t out_word,
	output logic out_valid,
	output logic full,
	output logic empty
);

	logic [burst_pkg::WORD_W-1:0] fifo_dout;
	logic signed [AW:0] fifo_count;
	burst_pkg::rd_tag_t rd;
	logic run;
	logic expire;

	// writes beyond a full FIFO are lost here
	shortfifo #(
		.dw(burst_pkg::WORD_W),
		.aw(AW)
	) i_shortfifo (
		.clk  (clk),
		.rst  (rst),
		.din  (din),
		.we   (we),
		.dout (fifo_dout),
		.re   (rd.re),
		.full (full),
		.empty(empty),
		.last (),
		.count(fifo_count)
	);

	// every write strobe restarts the idle count
	flush_timer #(
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) i_flush_timer (
		.clk   (clk),
		.rst   (rst),
		.run   (run),
		.kick  (we),
		.expire(expire)
	);

	burst_ctrl #(
		.AW       (AW),
		.BURST_LEN(BURST_LEN)
	) i_burst_ctrl (
		.clk   (clk),
		.rst   (rst),
		.hold  (hold),
		.count (fifo_count),
		.empty (empty),
		.expire(expire),
		.rd    (rd),
		.run   (run)
	);

	frame_tagger i_frame_tagger (
		.clk      (clk),
		.rst      (rst),
		.data     (fifo_dout),
		.rd       (rd),
		.out_word (out_word),
		.out_valid(out_valid)
	);

endmodule

// File: design/burst_pkg.sv
/*
 * shared definitions for the burst packer
 * word and sequence widths, controller state enum,
 * read request tag and output word structs
 */

package burst_pkg;

	// width of one sample word
	localparam int WORD_W = 16;

	// frame sequence number, wraps at 256
	localparam int SEQ_W = 8;

	// controller states
	typedef enum logic [1:0] {
		// waiting for a frame condition
		IDLE,
		// reading a full frame of BURST_LEN words
		BURST,
		// reading the remainder latched on entry
		FLUSH
	} ctrl_state_e;

	// read request from the controller, one per FIFO read
	typedef struct packed {
		logic re;
		logic first;
		logic last;
	} rd_tag_t;

	// framed output word
	typedef struct packed {
		logic [WORD_W-1:0] data;
		logic sof;
		logic eof;
		logic [SEQ_W-1:0] seq;
	} frame_word_t;

endpackage

// File: design/flush_timer.sv
/*
 * idle timer for the flush path
 * counts cycles without a write while run is high
 */

`timescale 1ns/1ps

module flush_timer #(
	parameter int FLUSH_CYCLES = 16
) (
	input logic clk,
	input logic rst,
	// controller idle with words waiting
	input logic run,
	// a write arrived this cycle
	input logic kick,
	// one cycle pulse once the idle period has elapsed
	output logic expire
);

	// one extra count value marks the saturated state after expiry
	localparam int CW = $clog2(FLUSH_CYCLES + 1);

	logic [CW-1:0] cnt;
	logic counting;

	// a kick or a stopped timer restarts the idle period
	assign counting = run && !kick;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (!counting) begin
			cnt <= '0;
		end else if (cnt != CW'(FLUSH_CYCLES)) begin
			// stops at FLUSH_CYCLES so that expire fires once
			cnt <= cnt + 1'b1;
		end
	end

	// cnt holds the number of earlier idle cycles in this period,
	// so this is the FLUSH_CYCLES-th one
	assign expire = counting && (cnt == CW'(FLUSH_CYCLES - 1));

endmodule

// File: design/frame_tagger.sv
/*
 * output register for framed words
 * adds sof/eof marks and the frame sequence number
 */

`timescale 1ns/1ps

module frame_tagger (
	input logic clk,
	input logic rst,
	// head of the FIFO, valid in the cycle of a read
	input logic [burst_pkg::WORD_W-1:0] data,
	// read strobe and frame marks from the controller
	input burst_pkg::rd_tag_t rd,
	output burst_pkg::frame_word_t out_word,
	output logic out_valid
);

	// sequence number of the frame being read
	logic [burst_pkg::SEQ_W-1:0] seq;

	// word and marks load only on a read
	always_ff @(posedge clk) begin
		if (rd.re) begin
			out_word.data <= data;
			out_word.sof <= rd.first;
			out_word.eof <= rd.last;
			out_word.seq <= seq;
		end
	end

	// valid follows the read strobe by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= rd.re;
		end
	end

	// advance after the last word of each frame, wraps naturally
	always_ff @(posedge clk) begin
		if (rst) begin
			seq <= '0;
		end else if (rd.re && rd.last) begin
			seq <= seq + 1'b1;
		end
	end

endmodule

// File: design/shortfifo.sv
/*
 * shortfifo: SRL-style short FIFO, depth 2**aw
 * abstract_dsr: one-bit dynamic shift register with addressed tap
 */

`timescale 1ns/1ps

module shortfifo #(
	parameter int dw = 16,
	parameter int aw = 3
) (
	input logic clk,
	input logic rst,
	// write side
	input logic [dw-1:0] din,
	input logic we,
	// read side, dout shows the oldest word whenever not empty
	output logic [dw-1:0] dout,
	input logic re,
	// status, all decoded from the read address
	output logic full,
	output logic empty,
	output logic last,
	// -1 when empty, 0 for one element, up to 2**aw - 1 when full
	output logic signed [aw:0] count
);

	localparam int len = 1 << aw;

	// one extra bit so that full and empty differ
	logic [aw:0] raddr;
	logic re_ok;
	logic we_ok;

	// reads on an empty FIFO are ignored
	assign re_ok = re && !empty;
	// a full FIFO still accepts a write when it is read in the same cycle
	assign we_ok = we && (!full || re_ok);

	// one shift register per data bit, all sharing the tap address
	for (genvar ix = 0; ix < dw; ix++) begin : g_bit
		abstract_dsr #(
			.aw(aw)
		) i_dsr (
			.clk (clk),
			.ce  (we_ok),
			.din (din[ix]),
			.addr(raddr[aw-1:0]),
			.dout(dout[ix])
		);
	end

	// address moves up on write, down on read, stays when both
	always_ff @(posedge clk) begin
		if (rst) begin
			// all ones is the empty position
			raddr <= '1;
		end else begin
			raddr <= raddr + (aw+1)'(we_ok) - (aw+1)'(re_ok);
		end
	end

	assign full = raddr == (aw+1)'(len - 1);
	assign empty = &raddr;
	assign last = raddr == '0;
	assign count = $signed(raddr);

endmodule

// newest bit enters at position zero, addr picks the tap
module abstract_dsr #(
	parameter int aw = 3
) (
	input logic clk,
	input logic ce,
	input logic din,
	input logic [aw-1:0] addr,
	output logic dout
);

	localparam int len = 1 << aw;

	logic [len-1:0] sr;

	always_ff @(posedge clk) begin
		if (ce) begin
			sr <= {sr[len-2:0], din};
		end
	end

	assign dout = sr[addr];

endmodule

// File: project.f
design/burst_pkg.sv
design/shortfifo.sv
design/flush_timer.sv
design/burst_ctrl.sv
design/frame_tagger.sv
design/burst_packer.sv
tb/burst_packer_assertions.sv
tb/burst_packer_tb.sv

// File: tb/burst_packer_assertions.sv
/*
 * checker for FIFO flags and frame marks
 * bound into shortfifo and burst_ctrl
 */

`timescale 1ns/1ps

module burst_packer_assertions (
	input logic clk,
	input logic rst,
	input logic full,
	input logic empty,
	input logic re,
	input logic first,
	input logic last
);

	// a frame was opened and not yet closed
	logic in_frame;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_frame <= 1'b0;
		end else if (re && first && !last) begin
			in_frame <= 1'b1;
		end else if (re && last) begin
			in_frame <= 1'b0;
		end
	end

	a_full_empty: assert property (@(posedge clk) disable iff (rst) !(full && empty))
		else $error("full and empty high together");

	a_read_empty: assert property (@(posedge clk) disable iff (rst) re |-> !empty)
		else $error("read strobe while the FIFO is empty");

	// new frame only after the previous one saw its last read
	a_first_closed: assert property (@(posedge clk) disable iff (rst)
		(re && first) |-> !in_frame)
		else $error("first read before the previous frame ended");

	a_last_open: assert property (@(posedge clk) disable iff (rst)
		(re && last && !first) |-> in_frame)
		else $error("last read without an open frame");

endmodule

bind shortfifo burst_packer_assertions i_fifo_chk (
	.clk(clk), .rst(rst), .full(full), .empty(empty), .re(re), .first(1'b0), .last(1'b0)
);

bind burst_ctrl burst_packer_assertions i_ctrl_chk (
	.clk(clk), .rst(rst), .full(1'b0), .empty(empty), .re(rd.re), .first(rd.first),
	.last(rd.last)
);

// File: tb/burst_packer_tb.sv
/*
 * testbench for the burst packer
 * scenario table, reference model queues, output monitor and summary
 */

`timescale 1ns/1ps

module burst_packer_tb;

	localparam int AW = 3;
	localparam int BURST_LEN = 4;
	localparam int FLUSH_CYCLES = 16;
	localparam int DEPTH = 1 << AW;
	localparam int NROWS = 8;
	localparam int DRAIN_LIMIT = 200;

	// write count, hold level and idle cycles with the expected word and frame totals
	typedef struct packed {
		int words;
		logic hold;
		int idle;
		int exp_acc;
		int exp_frames;
	} row_t;

	logic clk;
	logic rst;
	logic [burst_pkg::WORD_W-1:0] din;
	logic we;
	logic hold;
	burst_pkg::frame_word_t out_word;
	logic out_valid;
	logic full;
	logic empty;

	row_t rows [NROWS];
	// accepted words not yet part of a frame
	logic [burst_pkg::WORD_W-1:0] pend [$];
	// expected output words
	burst_pkg::frame_word_t exp_q [$];
	// set on the first word of each flushed frame
	bit flush_q [$];
	int frame_cnt = 0;
	int frames_seen = 0;
	int words_seen = 0;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	int last_write_cycle = 0;
	int seed;
	bit timed_out = 1'b0;

	burst_packer #(
		.AW(AW),
		.BURST_LEN(BURST_LEN),
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) i_burst_packer (
		.clk      (clk),
		.rst      (rst),
		.din      (din),
		.we       (we),
		.hold     (hold),
		.out_word (out_word),
		.out_valid(out_valid),
		.full     (full),
		.empty    (empty)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// rising edge count for the flush latency check
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic load_table();
		// two full frames in write order
		rows[0] = '{8, 1'b0, 10, 8, 2};
		// short remainders flushed after the idle timeout
		rows[1] = '{3, 1'b0, 20, 3, 1};
		rows[2] = '{1, 1'b0, 20, 1, 1};
		// hold lets the FIFO fill and three writes are lost
		rows[3] = '{11, 1'b1, 10, 8, 2};
		rows[4] = '{6, 1'b0, 20, 6, 2};
		rows[5] = '{12, 1'b0, 10, 12, 3};
		rows[6] = '{5, 1'b0, 20, 5, 2};
		rows[7] = '{9, 1'b1, 10, 8, 2};
	endtask

	// compare one output word with the head of the model
	task automatic sample_output();
		burst_pkg::frame_word_t exp_w;
		bit exp_flush;
		if (rst || !out_valid) begin
			return;
		end
		checks++;
		words_seen++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("unexpected output word %h at %0t with no frame pending",
				out_word.data, $time);
			return;
		end
		exp_w = exp_q.pop_front();
		exp_flush = flush_q.pop_front();
		if (out_word !== exp_w) begin
			errors++;
			$display("Mismatch at %0t: got %h/%b/%b/%0d expected %h/%b/%b/%0d",
				$time, out_word.data, out_word.sof, out_word.eof, out_word.seq,
				exp_w.data, exp_w.sof, exp_w.eof, exp_w.seq);
		end
		// a flush may not start before the idle period has passed
		if (exp_flush && (cycle_cnt - last_write_cycle < FLUSH_CYCLES)) begin
			errors++;
			$display("Mismatch at %0t: flush started %0d cycles after the last write",
				$time, cycle_cnt - last_write_cycle);
		end
		if (out_word.eof) begin
			frames_seen++;
		end
	endtask

	// every wait in the run goes through here so the monitor sees each cycle
	task automatic next_cycle();
		@(negedge clk);
		sample_output();
	endtask

	// move n pending words into one expected frame
	task automatic form_frame(input int n, input bit flush);
		burst_pkg::frame_word_t w;
		int i;
		for (i = 0; i < n; i++) begin
			w.data = pend.pop_front();
			w.sof = (i == 0);
			w.eof = (i == n - 1);
			w.seq = frame_cnt[burst_pkg::SEQ_W-1:0];
			exp_q.push_back(w);
			flush_q.push_back(flush && (i == 0));
		end
		frame_cnt++;
	endtask

	task automatic form_full_frames();
		while (pend.size() >= BURST_LEN) begin
			form_frame(BURST_LEN, 1'b0);
		end
	endtask

	// flags follow the write by one cycle
	task automatic check_full_flag(input bit exp_full);
		checks++;
		if (full !== exp_full) begin
			errors++;
			$display("Mismatch at %0t: full is %b, expected %b", $time, full, exp_full);
		end
	endtask

	task automatic wait_drain(output bit ok);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			next_cycle();
			n++;
		end
		ok = (exp_q.size() == 0);
	endtask

	task automatic check_reset_state();
		int i;
		int err0;
		err0 = errors;
		for (i = 0; i < 5; i++) begin
			next_cycle();
			checks++;
			if (out_valid !== 1'b0 || empty !== 1'b1 || full !== 1'b0) begin
				errors++;
				$display("Mismatch at %0t: after reset out_valid %b empty %b full %b",
					$time, out_valid, empty, full);
			end
		end
		$display("reset check: errors %0d", errors - err0);
	endtask

	task automatic run_row(input int r);
		int err0;
		int frames0;
		int words0;
		int acc;
		int dropped;
		int w;
		bit exp_full;
		bit ok;
		logic [31:0] rnd;
		err0 = errors;
		frames0 = frames_seen;
		words0 = words_seen;
		acc = 0;
		dropped = 0;
		exp_full = 1'b0;
		for (w = 0; w < rows[r].words; w++) begin
			next_cycle();
			check_full_flag(exp_full);
			rnd = $random(seed);
			din = rnd[burst_pkg::WORD_W-1:0];
			we = 1'b1;
			hold = rows[r].hold;
			// a write into a full FIFO is lost
			if (pend.size() < DEPTH) begin
				pend.push_back(din);
				acc++;
			end else begin
				dropped++;
			end
			last_write_cycle = cycle_cnt + 1;
			if (!rows[r].hold) begin
				form_full_frames();
			end
			exp_full = (pend.size() == DEPTH);
		end
		next_cycle();
		check_full_flag(exp_full);
		we = 1'b0;
		hold = 1'b0;
		// with hold released the full frames leave first and the remainder after the timeout
		form_full_frames();
		if (pend.size() != 0) begin
			form_frame(pend.size(), 1'b1);
		end
		for (w = 0; w < rows[r].idle; w++) begin
			next_cycle();
		end
		wait_drain(ok);
		if (!ok) begin
			timed_out = 1'b1;
			$display("timeout in row %0d, %0d output words never arrived", r, exp_q.size());
		end else begin
			checks += 3;
			if (empty !== 1'b1 || full !== 1'b0) begin
				errors++;
				$display("Mismatch at %0t: row %0d ends with empty %b full %b",
					$time, r, empty, full);
			end
			if (words_seen - words0 != rows[r].exp_acc) begin
				errors++;
				$display("Mismatch at %0t: row %0d gave %0d output words, expected %0d",
					$time, r, words_seen - words0, rows[r].exp_acc);
			end
			if (frames_seen - frames0 != rows[r].exp_frames) begin
				errors++;
				$display("Mismatch at %0t: row %0d gave %0d frames, expected %0d",
					$time, r, frames_seen - frames0, rows[r].exp_frames);
			end
		end
		$display("row %0d: wrote %0d accepted %0d dropped %0d frames %0d errors %0d",
			r, rows[r].words, acc, dropped, frames_seen - frames0, errors - err0);
	endtask

	initial begin
		int i;
		int r;
		rst = 1'b1;
		din = '0;
		we = 1'b0;
		hold = 1'b0;
		seed = 47;
		load_table();
		for (i = 0; i < 5; i++) begin
			@(negedge clk);
		end
		rst = 1'b0;
		check_reset_state();
		for (r = 0; r < NROWS && !timed_out; r++) begin
			run_row(r);
		end
		// nothing may trail the last frame
		for (i = 0; i < 5; i++) begin
			next_cycle();
		end
		$display("checks %0d errors %0d frames %0d", checks, errors, frames_seen);
		if (errors == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
